/* list.f */
design/cdc_fifo_pkg.sv
design/cdc_gray_pkg.sv
design/cdc_gray_sync.sv
design/cdc_fifo_ram.sv
design/cdc_fifo_push_ctrl.sv
design/cdc_fifo_pop_ctrl.sv
design/cdc_fifo_monitor.sv
design/cdc_fifo_top.sv
dv/cdc_fifo_tb.sv

/* Makefile */
# Verilator build and run of the dual-clock FIFO testbench
VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= cdc_fifo_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/cdc_fifo_tb.sv */
// Testbench for the dual-clock FIFO with independent push and pop clocks
// Covers reset values, fill under back-pressure, stall stability,
// random traffic against a queue model and a final drain
`default_nettype none

module cdc_fifo_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import cdc_fifo_pkg::*;

  localparam int          TRAFFIC_WORDS = 500;
  localparam int          CYCLE_LIMIT   = 20000;
  localparam logic [31:0] SEED          = 32'h1698;

  logic                   push_clk;
  logic                   pop_clk;
  logic                   rst;
  logic                   push_valid;
  logic [WIDTH-1:0]       push_data;
  logic                   push_ready;
  logic                   push_full;
  logic [COUNT_WIDTH-1:0] push_slots;
  logic                   pop_ready;
  logic                   pop_valid;
  logic                   pop_empty;
  logic [WIDTH-1:0]       pop_data;
  logic [COUNT_WIDTH-1:0] pop_items;

  // Reference model, oldest accepted push at the front
  logic [WIDTH-1:0] model_q [$];
  int               push_total;
  logic [31:0]      push_lfsr;
  logic [31:0]      pop_lfsr;
  logic [31:0]      rand_bits;
  logic             push_done;
  logic             stall_pending;
  logic [WIDTH-1:0] stall_data;
  logic [WIDTH-1:0] held_data;
  logic [WIDTH-1:0] expected_word;
  int               waited;

  cdc_fifo_top dut_i (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .rst       (rst),
    .push_valid(push_valid),
    .push_data (push_data),
    .push_ready(push_ready),
    .push_full (push_full),
    .push_slots(push_slots),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_empty (pop_empty),
    .pop_data  (pop_data),
    .pop_items (pop_items)
  );

  // 10 ns push clock, 14 ns pop clock
  always #5 push_clk = ~push_clk;
  always #7 pop_clk = ~pop_clk;

  // x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  // Next word the FIFO must deliver, taken out of the model
  function automatic logic [WIDTH-1:0] expected_pop();
    return model_q.pop_front();
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      stop_run($sformatf("FAIL at %0d ns: %s, got %0h, expected %0h",
                         $time, what, got, expected));
    end
  endtask

  // Push recorder, samples the handshake at the edge that accepts it
  always @(posedge push_clk) begin
    if (!rst) begin
      // Free slots may only under-report
      check_equal(32'(32'(push_slots) + 32'(model_q.size()) <= 32'(DEPTH)), 32'd1,
                  "push_slots above real free space");
      if (push_valid && push_ready) begin
        model_q.push_back(push_data);
        push_total++;
      end
    end
  end

  // Pop checker
  always @(posedge pop_clk) begin
    if (!rst) begin
      if (stall_pending) begin
        check_equal(32'(pop_valid), 32'd1, "pop_valid dropped while stalled");
        check_equal(32'(pop_data), 32'(stall_data), "pop_data changed while stalled");
      end
      check_equal(32'(32'(pop_items) <= 32'(model_q.size())), 32'd1,
                  "pop_items above stored words");
      if (pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          stop_run("A word was popped although nothing was pushed");
        end
        expected_word = expected_pop();
        check_equal(32'(pop_data), 32'(expected_word), "popped word out of order");
      end
      stall_pending = pop_valid && !pop_ready;
      stall_data    = pop_data;
    end
  end

  // Random pushes until the given number of words is accepted
  task automatic push_traffic(input int words);
    int          target;
    int          cycles;
    logic [31:0] bits;
    target = push_total + words;
    cycles = 0;
    while (push_total < target) begin
      if (cycles == CYCLE_LIMIT) begin
        stop_run("Timeout while waiting for the random pushes to be accepted");
      end
      draw_bits(1, push_lfsr, bits);
      push_valid = bits[0];
      draw_bits(WIDTH, push_lfsr, bits);
      push_data = bits[WIDTH-1:0];
      @(negedge push_clk);
      cycles++;
    end
    push_valid = 1'b0;
  endtask

  // Ready three times in four, until the push side is done
  task automatic pop_traffic();
    int          cycles;
    logic [31:0] bits;
    cycles = 0;
    while (!push_done) begin
      if (cycles == CYCLE_LIMIT) begin
        stop_run("Timeout while popping and waiting for the pushes to finish");
      end
      draw_bits(2, pop_lfsr, bits);
      pop_ready = |bits[1:0];
      @(negedge pop_clk);
      cycles++;
    end
    pop_ready = 1'b0;
  endtask

  initial begin
    push_clk      = 1'b0;
    pop_clk       = 1'b0;
    rst           = 1'b1;
    push_valid    = 1'b0;
    push_data     = '0;
    pop_ready     = 1'b0;
    push_lfsr     = SEED;
    pop_lfsr      = SEED;
    push_done     = 1'b0;
    stall_pending = 1'b0;

    // Two full pop_clk cycles, which also covers the push domain
    @(negedge pop_clk);
    rst = 1'b1;
    repeat (2) @(negedge pop_clk);
    rst = 1'b0;

    // Reset values
    check_equal(32'(push_full), 32'd0, "push_full after reset");
    check_equal(32'(push_slots), 32'(DEPTH), "push_slots after reset");
    check_equal(32'(pop_empty), 32'd1, "pop_empty after reset");
    check_equal(32'(pop_items), 32'd0, "pop_items after reset");
    check_equal(32'(pop_valid), 32'd0, "pop_valid after reset");

    // Local push reset still releasing
    waited = 0;
    while (!push_ready) begin
      if (waited == 20) begin
        stop_run("Timeout while waiting for push_ready to rise after reset");
      end
      @(negedge push_clk);
      waited++;
    end

    // Fill with the pop side stalled
    @(negedge push_clk);
    waited = 0;
    while (push_ready) begin
      if (waited == 4 * DEPTH) begin
        stop_run("Timeout while waiting for push_ready to fall during the fill");
      end
      push_valid = 1'b1;
      draw_bits(WIDTH, push_lfsr, rand_bits);
      push_data = rand_bits[WIDTH-1:0];
      @(negedge push_clk);
      waited++;
    end
    push_valid = 1'b0;
    check_equal(32'(push_total), 32'(DEPTH), "words accepted before full");
    check_equal(32'(push_full), 32'd1, "push_full after the fill");
    check_equal(32'(push_slots), 32'd0, "push_slots after the fill");

    waited = 0;
    while (pop_items != COUNT_WIDTH'(DEPTH)) begin
      if (waited == 20) begin
        stop_run("Timeout while waiting for pop_items to reach the FIFO depth");
      end
      @(negedge pop_clk);
      waited++;
    end

    // Stalled head word holds and is the oldest push
    held_data = pop_data;
    check_equal(32'(held_data), 32'(model_q[0]), "head word while stalled");
    repeat (3) begin
      @(negedge pop_clk);
      check_equal(32'(pop_valid), 32'd1, "pop_valid during directed stall");
      check_equal(32'(pop_data), 32'(held_data), "pop_data during directed stall");
    end

    // Random traffic in both domains
    fork
      begin
        @(negedge push_clk);
        push_traffic(TRAFFIC_WORDS);
        push_done = 1'b1;
      end
      begin
        @(negedge pop_clk);
        pop_traffic();
      end
    join

    // Drain what is left
    @(negedge pop_clk);
    pop_ready = 1'b1;
    waited = 0;
    while (model_q.size() != 0) begin
      if (waited == 200) begin
        stop_run("Timeout while waiting for the remaining words to drain");
      end
      @(negedge pop_clk);
      waited++;
    end
    waited = 0;
    while (!pop_empty) begin
      if (waited == 20) begin
        stop_run("Timeout while waiting for pop_empty after the drain");
      end
      @(negedge pop_clk);
      waited++;
    end
    pop_ready = 1'b0;

    // Freed slots travel back through the read pointer synchronizer
    @(negedge push_clk);
    waited = 0;
    while (push_slots != COUNT_WIDTH'(DEPTH)) begin
      if (waited == 20) begin
        stop_run("Timeout while waiting for push_slots to return to the FIFO depth");
      end
      @(negedge push_clk);
      waited++;
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule : cdc_fifo_tb

`default_nettype wire

/* design/cdc_fifo_top.sv */
// Top level of the dual-clock FIFO
// Wires the push and pop controllers, pointer synchronizers, RAM and monitor
`default_nettype none

module cdc_fifo_top (
  input  logic                                 push_clk,
  input  logic                                 pop_clk,
  input  logic                                 rst,
  input  logic                                 push_valid,
  input  logic [cdc_fifo_pkg::WIDTH-1:0]       push_data,
  output logic                                 push_ready,
  output logic                                 push_full,
  output logic [cdc_fifo_pkg::COUNT_WIDTH-1:0] push_slots,
  input  logic                                 pop_ready,
  output logic                                 pop_valid,
  output logic                                 pop_empty,
  output logic [cdc_fifo_pkg::WIDTH-1:0]       pop_data,
  output logic [cdc_fifo_pkg::COUNT_WIDTH-1:0] pop_items
);
  import cdc_fifo_pkg::*;
  import cdc_gray_pkg::*;

  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [PTR_WIDTH-1:0]  wr_ptr_gray;
  logic [PTR_WIDTH-1:0]  wr_ptr_gray_sync;
  logic [PTR_WIDTH-1:0]  rd_ptr_gray;
  logic [PTR_WIDTH-1:0]  rd_ptr_gray_sync;

  cdc_fifo_push_ctrl push_ctrl_i (
    .push_clk        (push_clk),
    .rst             (rst),
    .push_valid      (push_valid),
    .rd_ptr_gray_sync(rd_ptr_gray_sync),
    .push_ready      (push_ready),
    .push_full       (push_full),
    .push_slots      (push_slots),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_ptr_gray     (wr_ptr_gray)
  );

  // Write pointer into the pop domain
  cdc_gray_sync wr_sync_i (
    .clk     (pop_clk),
    .rst     (rst),
    .gray_in (wr_ptr_gray),
    .gray_out(wr_ptr_gray_sync)
  );

  // Read pointer back into the push domain
  cdc_gray_sync rd_sync_i (
    .clk     (push_clk),
    .rst     (rst),
    .gray_in (rd_ptr_gray),
    .gray_out(rd_ptr_gray_sync)
  );

  cdc_fifo_pop_ctrl pop_ctrl_i (
    .pop_clk         (pop_clk),
    .rst             (rst),
    .pop_ready       (pop_ready),
    .wr_ptr_gray_sync(wr_ptr_gray_sync),
    .pop_valid       (pop_valid),
    .pop_empty       (pop_empty),
    .pop_items       (pop_items),
    .rd_addr         (rd_addr),
    .rd_ptr_gray     (rd_ptr_gray)
  );

  // push_data goes straight into the array
  cdc_fifo_ram ram_i (
    .push_clk(push_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (push_data),
    .rd_addr (rd_addr),
    .rd_data (pop_data)
  );

  cdc_fifo_monitor monitor_i (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .rst       (rst),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_full (push_full),
    .push_slots(push_slots),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_empty (pop_empty),
    .pop_items (pop_items),
    .pop_data  (pop_data)
  );

endmodule : cdc_fifo_top

`default_nettype wire

/* design/cdc_fifo_monitor.sv */
// Simulation checker for the dual-clock FIFO ports
// Counts accepted transfers per domain and asserts handshake and status rules
// Instantiated inside the top level next to the DUT blocks
`default_nettype none

module cdc_fifo_monitor (
  input logic                                 push_clk,
  input logic                                 pop_clk,
  input logic                                 rst,
  input logic                                 push_valid,
  input logic                                 push_ready,
  input logic                                 push_full,
  input logic [cdc_fifo_pkg::COUNT_WIDTH-1:0] push_slots,
  input logic                                 pop_valid,
  input logic                                 pop_ready,
  input logic                                 pop_empty,
  input logic [cdc_fifo_pkg::COUNT_WIDTH-1:0] pop_items,
  input logic [cdc_fifo_pkg::WIDTH-1:0]       pop_data
);
  import cdc_fifo_pkg::*;

  logic [31:0] push_count;
  logic [31:0] pop_count;

  // Accepted pushes, push domain
  always_ff @(posedge push_clk) begin
    if (rst) begin
      push_count <= '0;
    end else if (push_valid && push_ready) begin
      push_count <= push_count + 32'd1;
    end
  end

  // Accepted pops, pop domain
  always_ff @(posedge pop_clk) begin
    if (rst) begin
      pop_count <= '0;
    end else if (pop_valid && pop_ready) begin
      pop_count <= pop_count + 32'd1;
    end
  end

  // Handshake rules
  no_ready_when_full_a: assert property (@(posedge push_clk) disable iff (rst)
    push_full |-> !push_ready);
  no_valid_when_empty_a: assert property (@(posedge pop_clk) disable iff (rst)
    pop_empty |-> !pop_valid);
  pop_stall_stable_a: assert property (@(posedge pop_clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

  // Flags agree with the counts they summarize
  full_vs_slots_a: assert property (@(posedge push_clk) disable iff (rst)
    push_full == (push_slots == '0));
  empty_vs_items_a: assert property (@(posedge pop_clk) disable iff (rst)
    pop_empty == (pop_items == '0));

  // Cross-domain bookkeeping, nothing appears from nowhere and nothing overflows
  pops_after_pushes_a: assert property (@(posedge pop_clk) disable iff (rst)
    pop_count <= push_count);
  occupancy_bound_a: assert property (@(posedge push_clk) disable iff (rst)
    (push_count - pop_count) <= 32'(DEPTH));

  fifo_full_c: cover property (@(posedge push_clk) disable iff (rst) push_full);

endmodule : cdc_fifo_monitor

`default_nettype wire

/* design/cdc_fifo_pop_ctrl.sv */
// Pop-domain controller of the dual-clock FIFO
// Owns the read pointer and derives empty, valid and item count
// from the write pointer synchronized out of the push domain
`default_nettype none

module cdc_fifo_pop_ctrl (
  input  logic                                 pop_clk,
  input  logic                                 rst,
  input  logic                                 pop_ready,
  input  logic [cdc_gray_pkg::PTR_WIDTH-1:0]   wr_ptr_gray_sync,
  output logic                                 pop_valid,
  output logic                                 pop_empty,
  output logic [cdc_fifo_pkg::COUNT_WIDTH-1:0] pop_items,
  output logic [cdc_fifo_pkg::ADDR_WIDTH-1:0]  rd_addr,
  output logic [cdc_gray_pkg::PTR_WIDTH-1:0]   rd_ptr_gray
);
  import cdc_fifo_pkg::*;
  import cdc_gray_pkg::*;

  logic                 rst_meta;
  logic                 pop_rst;
  logic                 pop_fire;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr_next;
  logic [PTR_WIDTH-1:0] wr_ptr_bin;
  logic [PTR_WIDTH-1:0] items_next;

  // Local reset, two flops in pop_clk
  always_ff @(posedge pop_clk) begin
    rst_meta <= rst;
    pop_rst  <= rst_meta;
  end

  // Head word sits at rd_addr until it is taken
  assign pop_valid   = !pop_empty;
  assign pop_fire    = pop_valid && pop_ready;
  assign rd_addr     = rd_ptr[ADDR_WIDTH-1:0];
  assign rd_ptr_next = rd_ptr + PTR_WIDTH'(pop_fire);

  // Write pointer lags the push side, so items can only under-report
  assign wr_ptr_bin = gray_to_bin(wr_ptr_gray_sync);
  assign items_next = wr_ptr_bin - rd_ptr_next;

  // Items and empty follow the removal at the same edge
  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      pop_items   <= '0;
      pop_empty   <= 1'b1;
    end else begin
      rd_ptr      <= rd_ptr_next;
      rd_ptr_gray <= bin_to_gray(rd_ptr_next);
      pop_items   <= COUNT_WIDTH'(items_next);
      pop_empty   <= (items_next == '0);
    end
  end

  // A read pointer passing the synced write pointer would wrap items past DEPTH
  items_in_range_a: assert property (@(posedge pop_clk) disable iff (pop_rst)
    pop_items <= COUNT_WIDTH'(DEPTH));

endmodule : cdc_fifo_pop_ctrl

`default_nettype wire

/* design/cdc_fifo_push_ctrl.sv */
// Push-domain controller of the dual-clock FIFO
// Owns the write pointer and derives full and free-slot status
// from the read pointer synchronized out of the pop domain
`default_nettype none

module cdc_fifo_push_ctrl (
  input  logic                                 push_clk,
  input  logic                                 rst,
  input  logic                                 push_valid,
  input  logic [cdc_gray_pkg::PTR_WIDTH-1:0]   rd_ptr_gray_sync,
  output logic                                 push_ready,
  output logic                                 push_full,
  output logic [cdc_fifo_pkg::COUNT_WIDTH-1:0] push_slots,
  output logic                                 wr_en,
  output logic [cdc_fifo_pkg::ADDR_WIDTH-1:0]  wr_addr,
  output logic [cdc_gray_pkg::PTR_WIDTH-1:0]   wr_ptr_gray
);
  import cdc_fifo_pkg::*;
  import cdc_gray_pkg::*;

  logic                   rst_meta;
  logic                   push_rst;
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   wr_ptr_next;
  logic [PTR_WIDTH-1:0]   rd_ptr_bin;
  logic [PTR_WIDTH-1:0]   used_next;
  logic [COUNT_WIDTH-1:0] slots_next;

  // Local reset, two flops in push_clk
  always_ff @(posedge push_clk) begin
    rst_meta <= rst;
    push_rst <= rst_meta;
  end

  // Accepted word is written at the same edge
  assign wr_en       = push_valid && push_ready;
  assign wr_addr     = wr_ptr[ADDR_WIDTH-1:0];
  assign wr_ptr_next = wr_ptr + PTR_WIDTH'(wr_en);

  // Read pointer lags the pop side, so slots can only under-report
  assign rd_ptr_bin = gray_to_bin(rd_ptr_gray_sync);
  assign used_next  = wr_ptr_next - rd_ptr_bin;
  assign slots_next = COUNT_WIDTH'(DEPTH) - COUNT_WIDTH'(used_next);

  // Status is registered from the post-write pointer
  always_ff @(posedge push_clk) begin
    if (push_rst) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
      push_slots  <= COUNT_WIDTH'(DEPTH);
      push_full   <= 1'b0;
      push_ready  <= 1'b0;
    end else begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= bin_to_gray(wr_ptr_next);
      push_slots  <= slots_next;
      push_full   <= (slots_next == '0);
      push_ready  <= (slots_next != '0);
    end
  end

  // A write needs a free entry by the current pointers, not only by the registered flags
  no_write_when_full_a: assert property (@(posedge push_clk) disable iff (push_rst)
    wr_en |-> (PTR_WIDTH'(wr_ptr - rd_ptr_bin) < PTR_WIDTH'(DEPTH)));

  slots_in_range_a: assert property (@(posedge push_clk) disable iff (push_rst)
    push_slots <= COUNT_WIDTH'(DEPTH));

endmodule : cdc_fifo_push_ctrl

`default_nettype wire

/* design/cdc_fifo_ram.sv */
// Storage array of the dual-clock FIFO
// Written in the push domain, read combinationally by the pop domain
`default_nettype none

module cdc_fifo_ram (
  input  logic                                push_clk,
  input  logic                                wr_en,
  input  logic [cdc_fifo_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [cdc_fifo_pkg::WIDTH-1:0]      wr_data,
  input  logic [cdc_fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [cdc_fifo_pkg::WIDTH-1:0]      rd_data
);
  import cdc_fifo_pkg::*;

  // Plain flop array, contents are only meaningful once written
  logic [WIDTH-1:0] mem [DEPTH];

  // One-cycle write
  always_ff @(posedge push_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read slot is stable while the pop side holds its pointer,
  // the push side never writes an occupied entry
  assign rd_data = mem[rd_addr];

endmodule : cdc_fifo_ram

`default_nettype wire

/* design/cdc_gray_sync.sv */
// Multi-flop synchronizer for a Gray-coded FIFO pointer
// Clocked by the destination domain; one instance per crossing direction
`default_nettype none

module cdc_gray_sync (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [cdc_gray_pkg::PTR_WIDTH-1:0] gray_in,
  output logic [cdc_gray_pkg::PTR_WIDTH-1:0] gray_out
);
  import cdc_gray_pkg::*;

  // Stage 0 samples the foreign domain, later stages settle it
  logic [PTR_WIDTH-1:0] stage_q [NUM_SYNC_STAGES];

  // Binary view of the synchronized pointer
  logic [PTR_WIDTH-1:0] bin_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_SYNC_STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= gray_in;
      for (int i = 1; i < NUM_SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign gray_out = stage_q[NUM_SYNC_STAGES-1];
  assign bin_out  = gray_to_bin(gray_out);

  // A faster source may step the pointer more than once between samples,
  // but it only moves forward and never by more than half its range
  ptr_forward_a: assert property (@(posedge clk) disable iff (rst)
    PTR_WIDTH'(bin_out - $past(bin_out)) <= PTR_WIDTH'(2 ** (PTR_WIDTH - 1)));

endmodule : cdc_gray_sync

`default_nettype wire

/* design/cdc_gray_pkg.sv */
// Clock-crossing definitions: pointer width, synchronizer depth and
// the binary/Gray conversions used on both sides of the FIFO
`default_nettype none

package cdc_gray_pkg;

  // Address bits plus one wrap bit to tell full from empty
  localparam int PTR_WIDTH = cdc_fifo_pkg::ADDR_WIDTH + 1;

  // Flops in each pointer synchronizer
  localparam int NUM_SYNC_STAGES = 2;

  function automatic logic [PTR_WIDTH-1:0] bin_to_gray(input logic [PTR_WIDTH-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it
  function automatic logic [PTR_WIDTH-1:0] gray_to_bin(input logic [PTR_WIDTH-1:0] gray);
    logic [PTR_WIDTH-1:0] bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : cdc_gray_pkg

`default_nettype wire

/* design/cdc_fifo_pkg.sv */
// Geometry of the dual-clock FIFO, shared by the controllers, RAM and monitor
// Import inside a module body, or use scoped names in port lists
`default_nettype none

package cdc_fifo_pkg;

  // Number of stored words
  localparam int DEPTH = 8;

  // Data word width
  localparam int WIDTH = 16;

  // Slots and items counts must be able to hold DEPTH itself
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // RAM address, one entry per pointer value below the wrap bit
  localparam int ADDR_WIDTH = $clog2(DEPTH);

endpackage : cdc_fifo_pkg

`default_nettype wire
